// File: list.f
hw/periph_pkg.sv
hw/host_bus_if.sv
hw/sync_fifo.sv
hw/sd_ctrl_regs.sv
hw/periph_decode.sv
hw/periph_top.sv
testbench/tb_periph.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_periph -o tb_periph_sim
./obj_dir/tb_periph_sim | tee sim.log

if grep -qx "TB PASSED" sim.log
then
  echo "simulation ok"
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

// File: testbench/periph_vectors.txt
// columns: op addr data expect (hex). op 1 write, 2 read-check, 3 rx push, 4 tx pop-check,
// 5 output-check (addr picks the output), 6 rx head check, 7 rx pop, 8 set detect/dip, 0 end
5 00000 00000000 00000000 // led after reset
5 00006 00000000 00000000 // cmd start
5 00007 00000000 00000000 // resets
2 10014 00000000 00000005 // status, both fifos empty
1 10000 FFFFFFFF 00000000 // align, 2 bits kept
2 10040 00000000 00000003
5 00001 00000000 00000003
1 10008 12345678 00000000 // cmd arg
2 10048 00000000 12345678
5 00002 00000000 12345678
1 1000C 0000006A 00000000 // cmd index
2 1004C 00000000 0000002A
5 00003 00000000 0000002A
1 10010 0000002B 00000000 // data start 5, setting 3
2 10050 00000000 0000002B
5 00004 00000000 00000003
5 00005 00000000 00000005
1 10014 00000001 00000000 // start level
2 10054 00000000 00000001
5 00006 00000000 00000001
1 10014 00000000 00000000
5 00006 00000000 00000000
1 10018 0000000D 00000000 // resets, data reset still 0
2 10058 00000000 0000000D
5 00007 00000000 0000000D
1 1001C ABCD1234 00000000 // block count, 16 bits kept
2 1005C 00000000 00001234
5 00008 00000000 00001234
1 10020 0000F200 00000000 // block size
2 10060 00000000 00000200
5 00009 00000000 00000200
1 10024 0001E848 00000000 // timeout
2 10064 00000000 0001E848
5 0000A 00000000 0001E848
1 1003C 123456A5 00000000 // led, 8 bits kept
5 00000 00000000 000000A5
8 00000 0001B00F 00000000 // detect high, dip B00F
2 10030 00000000 00000001
2 1007C 00000000 0000B00F
2 10000 00000000 DEADBEEF // unlisted read offset
2 00000 00000000 00000000 // keyboard region
2 08000 00000000 00000000 // framebuffer region
1 14000 11111111 00000000 // tx write while fifos cleared
2 1002C 00000000 00000000
1 10018 0000000F 00000000 // release data reset
1 14000 AAAA0001 00000000
1 14000 AAAA0002 00000000
1 14000 AAAA0003 00000000
2 1002C 00000000 00000003
4 00000 00000000 AAAA0001
4 00000 00000000 AAAA0002
4 00000 00000000 AAAA0003
2 1002C 00000000 00000000
3 00000 00000000 00000000 // engine pushes four words
3 00000 00000000 00000000
3 00000 00000000 00000000
3 00000 00000000 00000000
2 10028 00000000 00000004
2 10014 00000000 00000004 // tx empty, rx not empty
6 18000 00000000 00000000
7 18000 00000000 00000000
6 18004 00000000 00000000
7 18000 00000000 00000000
2 10028 00000000 00000002
6 1807C 00000000 00000000
7 18000 00000000 00000000
6 18000 00000000 00000000
7 18000 00000000 00000000
2 10028 00000000 00000000
1 14000 0000C000 00000000 // fill the tx fifo
1 14000 0000C001 00000000
1 14000 0000C002 00000000
1 14000 0000C003 00000000
1 14000 0000C004 00000000
1 14000 0000C005 00000000
1 14000 0000C006 00000000
1 14000 0000C007 00000000
1 14000 0000C008 00000000
1 14000 0000C009 00000000
1 14000 0000C00A 00000000
1 14000 0000C00B 00000000
1 14000 0000C00C 00000000
1 14000 0000C00D 00000000
2 1002C 00000000 8000000E // almost full at 14
1 14000 0000C00E 00000000
1 14000 0000C00F 00000000
2 1002C 00000000 C0000010 // full at 16
2 10014 00000000 00000009
1 14000 0000C010 00000000 // push to a full fifo
2 1002C 00000000 D0000010
1 18000 00000000 00000000 // pop of the empty rx fifo
2 10028 00000000 20000000
1 10018 0000000D 00000000 // data reset low clears both
2 1002C 00000000 00000000
2 10028 00000000 00000000
2 10014 00000000 00000005
0 00000 00000000 00000000

// File: testbench/tb_periph.sv
// Testbench for periph_top that replays the vector file on the host bus
// and plays the SD engine side by pushing rx words and popping tx words.
`timescale 1ns/100ps
`default_nettype none

module tb_periph;

  localparam int AW      = periph_pkg::ADDR_W;
  localparam int DW      = periph_pkg::DATA_W;
  localparam int MAX_VEC = 128;

  logic                              msoc_clk;
  logic                              rstn;
  logic                              hid_req, hid_we;
  logic [AW-1:0]                     hid_addr;
  logic [DW-1:0]                     hid_wdata, hid_rdata;
  logic                              sd_detect;
  logic [periph_pkg::DIP_W-1:0]      from_dip;
  logic [periph_pkg::LED_W-1:0]      to_led;
  logic [periph_pkg::ALIGN_W-1:0]    sd_align;
  logic [DW-1:0]                     sd_cmd_arg, sd_timeout;
  logic [periph_pkg::CMD_IDX_W-1:0]  sd_cmd_idx;
  logic [periph_pkg::SETTING_W-1:0]  sd_setting, sd_data_start;
  logic                              sd_cmd_start, sd_reset, sd_clk_rst;
  logic                              sd_data_rst, sd_cmd_rst;
  logic [periph_pkg::BLKCNT_W-1:0]   sd_blkcnt;
  logic [periph_pkg::BLKSIZE_W-1:0]  sd_blksize;
  logic                              sd_tx_rd, sd_rx_wr;
  logic [DW-1:0]                     sd_tx_data, sd_rx_data;

  logic [31:0] vec_mem [0:4*MAX_VEC-1];
  logic [31:0] rx_model [$];          // engine words still waiting in the rx FIFO
  logic [31:0] lcg_state;
  int          n_vec  = 0;
  int          checks = 0;
  int          errors = 0;
  bit          loaded = 1'b0;

  periph_top u_dut (
    .msoc_clk(msoc_clk), .rstn(rstn),
    .hid_req_i(hid_req), .hid_we_i(hid_we), .hid_addr_i(hid_addr),
    .hid_wdata_i(hid_wdata), .hid_rdata_o(hid_rdata),
    .sd_detect_i(sd_detect), .from_dip_i(from_dip), .to_led_o(to_led),
    .sd_align_o(sd_align), .sd_cmd_arg_o(sd_cmd_arg), .sd_cmd_idx_o(sd_cmd_idx),
    .sd_setting_o(sd_setting), .sd_data_start_o(sd_data_start),
    .sd_cmd_start_o(sd_cmd_start), .sd_reset_o(sd_reset), .sd_clk_rst_o(sd_clk_rst),
    .sd_data_rst_o(sd_data_rst), .sd_cmd_rst_o(sd_cmd_rst),
    .sd_blkcnt_o(sd_blkcnt), .sd_blksize_o(sd_blksize), .sd_timeout_o(sd_timeout),
    .sd_tx_rd_i(sd_tx_rd), .sd_tx_data_o(sd_tx_data),
    .sd_rx_wr_i(sd_rx_wr), .sd_rx_data_i(sd_rx_data)
  );

  always #20 msoc_clk = ~msoc_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // output index used by the output-check vectors
  function automatic logic [31:0] output_value(input logic [3:0] sel);
    case (sel)
      4'd0:    return 32'(to_led);
      4'd1:    return 32'(sd_align);
      4'd2:    return sd_cmd_arg;
      4'd3:    return 32'(sd_cmd_idx);
      4'd4:    return 32'(sd_setting);
      4'd5:    return 32'(sd_data_start);
      4'd6:    return 32'(sd_cmd_start);
      4'd7:    return 32'({sd_reset, sd_clk_rst, sd_data_rst, sd_cmd_rst});
      4'd8:    return 32'(sd_blkcnt);
      4'd9:    return 32'(sd_blksize);
      4'd10:   return sd_timeout;
      default: return 32'hFFFFFFFF;
    endcase
  endfunction

  function automatic string output_name(input logic [3:0] sel);
    case (sel)
      4'd0:    return "to_led_o";
      4'd1:    return "sd_align_o";
      4'd2:    return "sd_cmd_arg_o";
      4'd3:    return "sd_cmd_idx_o";
      4'd4:    return "sd_setting_o";
      4'd5:    return "sd_data_start_o";
      4'd6:    return "sd_cmd_start_o";
      4'd7:    return "sd_reset/clk/data/cmd_rst_o";
      4'd8:    return "sd_blkcnt_o";
      4'd9:    return "sd_blksize_o";
      4'd10:   return "sd_timeout_o";
      default: return "unknown output";
    endcase
  endfunction

  task automatic log_mismatch(input string name, input int idx, input logic [31:0] got,
                              input logic [31:0] exp_v);
    errors++;
    $display("ERROR %s got %h expected %h at vector %0d", name, got, exp_v, idx);
  endtask

  task automatic fail_step(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic host_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
    @(posedge msoc_clk);
    #2;
    hid_req   = 1'b1;
    hid_we    = 1'b1;
    hid_addr  = addr;
    hid_wdata = data;
    @(posedge msoc_clk);
    #2;
    hid_req = 1'b0;
    hid_we  = 1'b0;
  endtask

  // read data is registered, so it is sampled one edge after the address
  task automatic host_read(input logic [AW-1:0] addr, output logic [DW-1:0] data);
    @(posedge msoc_clk);
    #2;
    hid_req  = 1'b1;
    hid_we   = 1'b0;
    hid_addr = addr;
    @(posedge msoc_clk);
    #2;
    data    = hid_rdata;
    hid_req = 1'b0;
  endtask

  task automatic engine_push(input logic [DW-1:0] data);
    @(posedge msoc_clk);
    #2;
    sd_rx_wr   = 1'b1;
    sd_rx_data = data;
    @(posedge msoc_clk);
    #2;
    sd_rx_wr = 1'b0;
  endtask

  task automatic engine_pop(output logic [DW-1:0] head);
    @(posedge msoc_clk);
    #2;
    head     = sd_tx_data;            // head shown before the pop
    sd_tx_rd = 1'b1;
    @(posedge msoc_clk);
    #2;
    sd_tx_rd = 1'b0;
  endtask

  initial
  begin
    logic [31:0] op, addr, data, exp_v, got;
    msoc_clk   = 1'b0;
    rstn       = 1'b0;
    hid_req    = 1'b0;
    hid_we     = 1'b0;
    hid_addr   = '0;
    hid_wdata  = '0;
    sd_detect  = 1'b0;
    from_dip   = '0;
    sd_tx_rd   = 1'b0;
    sd_rx_wr   = 1'b0;
    sd_rx_data = '0;
    lcg_state  = 32'd15170;
    $readmemh("testbench/periph_vectors.txt", vec_mem);
    while (n_vec < MAX_VEC && vec_mem[4*n_vec] != 32'd0)
      n_vec++;
    loaded = 1'b1;
    if (n_vec == 0)
      fail_step("no vectors were loaded from the vector file");
    repeat (2) @(posedge msoc_clk);
    #2;
    rstn = 1'b1;
    // every register output and the read data start at zero
    for (int s = 0; s <= 10; s++)
    begin
      checks++;
      if (output_value(4'(s)) !== 32'd0)
      begin
        errors++;
        $display("ERROR %s got %h expected %h after reset", output_name(4'(s)),
                 output_value(4'(s)), 32'd0);
      end
    end
    checks++;
    if (hid_rdata !== '0)
    begin
      errors++;
      $display("ERROR hid_rdata_o got %h expected %h after reset", hid_rdata, 32'd0);
    end
    for (int i = 0; i < n_vec; i++)
    begin
      op    = vec_mem[4*i];
      addr  = vec_mem[4*i+1];
      data  = vec_mem[4*i+2];
      exp_v = vec_mem[4*i+3];
      case (op)
        32'd1: host_write(addr[AW-1:0], data);
        32'd2:
        begin
          checks++;
          host_read(addr[AW-1:0], got);
          if (got !== exp_v)
            log_mismatch("hid_rdata_o", i, got, exp_v);
        end
        32'd3:
        begin
          lcg_state = lcg_next(lcg_state);
          engine_push(lcg_state);
          rx_model.push_back(lcg_state);
        end
        32'd4:
        begin
          checks++;
          engine_pop(got);
          if (got !== exp_v)
            log_mismatch("sd_tx_data_o", i, got, exp_v);
        end
        32'd5:
        begin
          checks++;
          @(posedge msoc_clk);
          #2;
          got = output_value(addr[3:0]);
          if (got !== exp_v)
            log_mismatch(output_name(addr[3:0]), i, got, exp_v);
        end
        32'd6:
        begin
          checks++;
          if (rx_model.size() == 0)
            fail_step($sformatf("rx head check at vector %0d with nothing pushed", i));
          else
          begin
            host_read(addr[AW-1:0], got);
            if (got !== rx_model[0])
              log_mismatch("hid_rdata_o", i, got, rx_model[0]);
          end
        end
        32'd7:
        begin
          host_write(addr[AW-1:0], 32'd0);   // host write to SDRX pops the head
          if (rx_model.size() == 0)
            fail_step($sformatf("rx pop at vector %0d with nothing pushed", i));
          else
            got = rx_model.pop_front();
        end
        32'd8:
        begin
          @(posedge msoc_clk);
          #2;
          sd_detect = data[16];
          from_dip  = data[15:0];
        end
        default: fail_step($sformatf("unknown opcode %0h at vector %0d", op, i));
      endcase
    end
    @(posedge msoc_clk);
    $display("vectors %0d, checks %0d, errors %0d", n_vec, checks, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // every vector takes at most two clocks
  initial
  begin
    wait (loaded);
    repeat (n_vec * 2 + 100) @(posedge msoc_clk);
    $display("timeout after %0d clocks, the vectors did not complete", n_vec * 2 + 100);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
// Top level of the SD host-bus block: register bank, decoder and two FIFOs.
// The SD engine sits outside and talks through the sd_tx and sd_rx ports.
`timescale 1ns/100ps
`default_nettype none

module periph_top (
  input  wire logic                                msoc_clk,
  input  wire logic                                rstn,
  input  wire logic                                hid_req_i,
  input  wire logic                                hid_we_i,
  input  wire logic [periph_pkg::ADDR_W-1:0]       hid_addr_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       hid_wdata_i,
  output logic      [periph_pkg::DATA_W-1:0]       hid_rdata_o,
  input  wire logic                                sd_detect_i,
  input  wire logic [periph_pkg::DIP_W-1:0]        from_dip_i,
  output logic      [periph_pkg::LED_W-1:0]        to_led_o,
  output logic      [periph_pkg::ALIGN_W-1:0]      sd_align_o,
  output logic      [periph_pkg::DATA_W-1:0]       sd_cmd_arg_o,
  output logic      [periph_pkg::CMD_IDX_W-1:0]    sd_cmd_idx_o,
  output logic      [periph_pkg::SETTING_W-1:0]    sd_setting_o,
  output logic      [periph_pkg::SETTING_W-1:0]    sd_data_start_o,
  output logic                                     sd_cmd_start_o,
  output logic                                     sd_reset_o,
  output logic                                     sd_clk_rst_o,
  output logic                                     sd_data_rst_o,
  output logic                                     sd_cmd_rst_o,
  output logic      [periph_pkg::BLKCNT_W-1:0]     sd_blkcnt_o,
  output logic      [periph_pkg::BLKSIZE_W-1:0]    sd_blksize_o,
  output logic      [periph_pkg::DATA_W-1:0]       sd_timeout_o,
  input  wire logic                                sd_tx_rd_i,
  output logic      [periph_pkg::DATA_W-1:0]       sd_tx_data_o,
  input  wire logic                                sd_rx_wr_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       sd_rx_data_i
);

  logic                          detect, fifo_clear;
  logic [periph_pkg::DIP_W-1:0]  dip;
  logic                          tx_push, rx_pop;
  logic                          tx_empty, tx_full, rx_empty, rx_full;
  logic [periph_pkg::DATA_W-1:0] tx_status, rx_status, rx_head;

  host_bus_if u_bus ();

  assign u_bus.req   = hid_req_i;
  assign u_bus.we    = hid_we_i;
  assign u_bus.addr  = hid_addr_i;
  assign u_bus.wdata = hid_wdata_i;
  assign fifo_clear  = ~sd_data_rst_o; // FIFOs held empty until data reset bit is set

  sd_ctrl_regs u_regs (
    .msoc_clk, .rstn, .bus(u_bus.ctrl), .sd_detect_i, .from_dip_i,
    .sd_align_o, .sd_cmd_arg_o, .sd_cmd_idx_o, .sd_setting_o, .sd_data_start_o,
    .sd_cmd_start_o, .sd_reset_o, .sd_clk_rst_o, .sd_data_rst_o, .sd_cmd_rst_o,
    .sd_blkcnt_o, .sd_blksize_o, .sd_timeout_o, .to_led_o,
    .detect_o(detect), .dip_o(dip)
  );

  periph_decode u_decode (
    .msoc_clk, .rstn, .bus(u_bus.dec),
    .sd_align_i(sd_align_o), .sd_cmd_arg_i(sd_cmd_arg_o), .sd_cmd_idx_i(sd_cmd_idx_o),
    .sd_setting_i(sd_setting_o), .sd_data_start_i(sd_data_start_o),
    .sd_cmd_start_i(sd_cmd_start_o), .sd_reset_i(sd_reset_o), .sd_clk_rst_i(sd_clk_rst_o),
    .sd_data_rst_i(sd_data_rst_o), .sd_cmd_rst_i(sd_cmd_rst_o),
    .sd_blkcnt_i(sd_blkcnt_o), .sd_blksize_i(sd_blksize_o), .sd_timeout_i(sd_timeout_o),
    .detect_i(detect), .dip_i(dip),
    .tx_status_i(tx_status), .rx_status_i(rx_status),
    .tx_empty_i(tx_empty), .tx_full_i(tx_full), .rx_empty_i(rx_empty), .rx_full_i(rx_full),
    .rx_head_i(rx_head), .tx_push_o(tx_push), .rx_pop_o(rx_pop), .hid_rdata_o
  );

  sync_fifo #(.WIDTH(periph_pkg::DATA_W), .DEPTH(periph_pkg::FIFO_DEPTH)) u_tx_fifo (
    .msoc_clk, .rstn, .clear_i(fifo_clear),
    .push_i(tx_push), .din_i(hid_wdata_i),
    .pop_i(sd_tx_rd_i), .dout_o(sd_tx_data_o),
    .empty_o(tx_empty), .full_o(tx_full), .status_o(tx_status)
  );

  sync_fifo #(.WIDTH(periph_pkg::DATA_W), .DEPTH(periph_pkg::FIFO_DEPTH)) u_rx_fifo (
    .msoc_clk, .rstn, .clear_i(fifo_clear),
    .push_i(sd_rx_wr_i), .din_i(sd_rx_data_i),
    .pop_i(rx_pop), .dout_o(rx_head),
    .empty_o(rx_empty), .full_o(rx_full), .status_o(rx_status)
  );

endmodule

`default_nettype wire

// File: hw/periph_decode.sv
// Region decode for the host bus: FIFO strobes and registered read data.
// Read data follows the address by one clock; no read strobe is needed.
`timescale 1ns/100ps
`default_nettype none

module periph_decode (
  input  wire logic                                msoc_clk,
  input  wire logic                                rstn,
  host_bus_if.dec                                  bus,
  input  wire logic [periph_pkg::ALIGN_W-1:0]      sd_align_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       sd_cmd_arg_i,
  input  wire logic [periph_pkg::CMD_IDX_W-1:0]    sd_cmd_idx_i,
  input  wire logic [periph_pkg::SETTING_W-1:0]    sd_setting_i,
  input  wire logic [periph_pkg::SETTING_W-1:0]    sd_data_start_i,
  input  wire logic                                sd_cmd_start_i,
  input  wire logic                                sd_reset_i,
  input  wire logic                                sd_clk_rst_i,
  input  wire logic                                sd_data_rst_i,
  input  wire logic                                sd_cmd_rst_i,
  input  wire logic [periph_pkg::BLKCNT_W-1:0]     sd_blkcnt_i,
  input  wire logic [periph_pkg::BLKSIZE_W-1:0]    sd_blksize_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       sd_timeout_i,
  input  wire logic                                detect_i,
  input  wire logic [periph_pkg::DIP_W-1:0]        dip_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       tx_status_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       rx_status_i,
  input  wire logic                                tx_empty_i,
  input  wire logic                                tx_full_i,
  input  wire logic                                rx_empty_i,
  input  wire logic                                rx_full_i,
  input  wire logic [periph_pkg::DATA_W-1:0]       rx_head_i,
  output logic                                     tx_push_o,
  output logic                                     rx_pop_o,
  output logic      [periph_pkg::DATA_W-1:0]       hid_rdata_o
);

  localparam int DW = periph_pkg::DATA_W;

  logic [3:0]             region_oh;
  logic                   host_wr;
  periph_pkg::sd_rd_off_e rd_off;
  logic [DW-1:0]          sd_word, rdata_next;

  always_comb
  begin
    for (int i = 0; i < 4; i++)
      region_oh[i] = (bus.addr[periph_pkg::ADDR_W-1 -: 2] == 2'(i));
  end

  assign host_wr   = bus.req & bus.we;
  assign tx_push_o = host_wr & region_oh[periph_pkg::SDCTRL] &
                     bus.addr[periph_pkg::TXFIFO_SEL_BIT];
  assign rx_pop_o  = host_wr & region_oh[periph_pkg::SDRX];   // write pops rx head
  assign rd_off    = periph_pkg::sd_rd_off_e'(bus.addr[6:2]);

  always_comb
  begin
    case (rd_off)
      periph_pkg::STATUS:     sd_word = DW'({tx_full_i, tx_empty_i, rx_full_i, rx_empty_i});
      periph_pkg::RX_STAT:    sd_word = rx_status_i;
      periph_pkg::TX_STAT:    sd_word = tx_status_i;
      periph_pkg::DETECT:     sd_word = DW'(detect_i);
      periph_pkg::ALIGN_RB:   sd_word = DW'(sd_align_i);
      periph_pkg::CMD_ARG_RB: sd_word = sd_cmd_arg_i;
      periph_pkg::CMD_IDX_RB: sd_word = DW'(sd_cmd_idx_i);
      periph_pkg::SETTING_RB: sd_word = DW'({sd_data_start_i, sd_setting_i});
      periph_pkg::START_RB:   sd_word = DW'(sd_cmd_start_i);
      periph_pkg::RESETS_RB:  sd_word = DW'({sd_reset_i, sd_clk_rst_i,
                                             sd_data_rst_i, sd_cmd_rst_i});
      periph_pkg::BLKCNT_RB:  sd_word = DW'(sd_blkcnt_i);
      periph_pkg::BLKSIZE_RB: sd_word = DW'(sd_blksize_i);
      periph_pkg::TIMEOUT_RB: sd_word = sd_timeout_i;
      periph_pkg::DIP:        sd_word = DW'(dip_i);
      default:                sd_word = periph_pkg::RD_DEFAULT;
    endcase
  end

  // KEYB and FSTORE are not present here, so they contribute zero
  assign rdata_next = ({DW{region_oh[periph_pkg::SDCTRL]}} & sd_word) |
                      ({DW{region_oh[periph_pkg::SDRX]}} & rx_head_i);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
      hid_rdata_o <= '0;
    else
      hid_rdata_o <= rdata_next;
  end

endmodule

`default_nettype wire

// File: hw/sd_ctrl_regs.sv
// SD control register bank written from the host bus in region SDCTRL.
// Also samples card detect and the DIP switches for readback.
`timescale 1ns/100ps
`default_nettype none

module sd_ctrl_regs (
  input  wire logic                                msoc_clk,
  input  wire logic                                rstn,
  host_bus_if.ctrl                                 bus,
  input  wire logic                                sd_detect_i,
  input  wire logic [periph_pkg::DIP_W-1:0]        from_dip_i,
  output logic      [periph_pkg::ALIGN_W-1:0]      sd_align_o,
  output logic      [periph_pkg::DATA_W-1:0]       sd_cmd_arg_o,
  output logic      [periph_pkg::CMD_IDX_W-1:0]    sd_cmd_idx_o,
  output logic      [periph_pkg::SETTING_W-1:0]    sd_setting_o,
  output logic      [periph_pkg::SETTING_W-1:0]    sd_data_start_o,
  output logic                                     sd_cmd_start_o,
  output logic                                     sd_reset_o,
  output logic                                     sd_clk_rst_o,
  output logic                                     sd_data_rst_o,
  output logic                                     sd_cmd_rst_o,
  output logic      [periph_pkg::BLKCNT_W-1:0]     sd_blkcnt_o,
  output logic      [periph_pkg::BLKSIZE_W-1:0]    sd_blksize_o,
  output logic      [periph_pkg::DATA_W-1:0]       sd_timeout_o,
  output logic      [periph_pkg::LED_W-1:0]        to_led_o,
  output logic                                     detect_o,
  output logic      [periph_pkg::DIP_W-1:0]        dip_o
);

  logic                   reg_wr;
  periph_pkg::sd_wr_off_e wr_off;

  // bit 14 set belongs to the tx FIFO, not to this bank
  assign reg_wr = bus.req & bus.we & ~bus.addr[periph_pkg::TXFIFO_SEL_BIT] &
                  (bus.addr[periph_pkg::ADDR_W-1 -: 2] == periph_pkg::SDCTRL);
  assign wr_off = periph_pkg::sd_wr_off_e'(bus.addr[5:2]);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      sd_align_o      <= '0;
      sd_cmd_arg_o    <= '0;
      sd_cmd_idx_o    <= '0;
      sd_setting_o    <= '0;
      sd_data_start_o <= '0;
      sd_cmd_start_o  <= 1'b0;
      sd_reset_o      <= 1'b0;
      sd_clk_rst_o    <= 1'b0;
      sd_data_rst_o   <= 1'b0;
      sd_cmd_rst_o    <= 1'b0;
      sd_blkcnt_o     <= '0;
      sd_blksize_o    <= '0;
      sd_timeout_o    <= '0;
      to_led_o        <= '0;
      detect_o        <= 1'b0;
      dip_o           <= '0;
    end
    else
    begin
      detect_o <= sd_detect_i;        // one cycle of capture delay
      dip_o    <= from_dip_i;
      if (reg_wr)
      begin
        case (wr_off)
          periph_pkg::ALIGN:   sd_align_o   <= bus.wdata[periph_pkg::ALIGN_W-1:0];
          periph_pkg::CMD_ARG: sd_cmd_arg_o <= bus.wdata;
          periph_pkg::CMD_IDX: sd_cmd_idx_o <= bus.wdata[periph_pkg::CMD_IDX_W-1:0];
          periph_pkg::SETTING: {sd_data_start_o, sd_setting_o} <=
                                 bus.wdata[2*periph_pkg::SETTING_W-1:0];
          periph_pkg::START:   sd_cmd_start_o <= bus.wdata[0]; // level, host clears it
          periph_pkg::RESETS:  {sd_reset_o, sd_clk_rst_o, sd_data_rst_o, sd_cmd_rst_o} <=
                                 bus.wdata[periph_pkg::RESETS_W-1:0];
          periph_pkg::BLKCNT:  sd_blkcnt_o  <= bus.wdata[periph_pkg::BLKCNT_W-1:0];
          periph_pkg::BLKSIZE: sd_blksize_o <= bus.wdata[periph_pkg::BLKSIZE_W-1:0];
          periph_pkg::TIMEOUT: sd_timeout_o <= bus.wdata;
          periph_pkg::LED:     to_led_o     <= bus.wdata[periph_pkg::LED_W-1:0];
          default:             ;             // unlisted offsets ignored
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
// Single-clock first-word-fall-through FIFO with occupancy count.
// Sticky error flags and the count are packed into a 32-bit status word.
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  wire logic                          msoc_clk,
  input  wire logic                          rstn,
  input  wire logic                          clear_i,
  input  wire logic                          push_i,
  input  wire logic [WIDTH-1:0]              din_i,
  input  wire logic                          pop_i,
  output logic      [WIDTH-1:0]              dout_o,
  output logic                               empty_o,
  output logic                               full_o,
  output logic      [periph_pkg::DATA_W-1:0] status_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PAD_W = periph_pkg::DATA_W - 4 - periph_pkg::FIFO_CNT_W;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  logic             rd_err, wr_err;
  logic             do_push, do_pop, almost_full;

  assign empty_o     = (count == '0);
  assign full_o      = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(DEPTH - 2));
  assign do_push     = push_i & ~full_o;
  assign do_pop      = pop_i & ~empty_o;
  assign dout_o      = mem[rd_ptr]; // head always visible

  always_ff @(posedge msoc_clk)
  begin
    if (do_push && !clear_i)
    begin
      mem[wr_ptr] <= din_i;
    end
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rd_err <= 1'b0;
      wr_err <= 1'b0;
    end
    else if (clear_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      rd_err <= 1'b0;
      wr_err <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      if (pop_i && empty_o)
        rd_err <= 1'b1;                 // sticky until clear
      if (push_i && full_o)
        wr_err <= 1'b1;
    end
  end

  assign status_o = {almost_full, full_o, rd_err, wr_err, {PAD_W{1'b0}},
                     periph_pkg::FIFO_CNT_W'(count)};

endmodule

`default_nettype wire

// File: hw/host_bus_if.sv
// Host request bundle shared by the register bank and the decoder.
// The top drives every signal from its hid ports; consumers only read.
`timescale 1ns/100ps
`default_nettype none

interface host_bus_if;

  logic                           req;
  logic                           we;
  logic [periph_pkg::ADDR_W-1:0]  addr;
  logic [periph_pkg::DATA_W-1:0]  wdata;

  modport ctrl (
    input req,
    input we,
    input addr,
    input wdata
  );

  modport dec (
    input req,
    input we,
    input addr,
    input wdata
  );

endinterface

`default_nettype wire

// File: hw/periph_pkg.sv
// Shared address map, register offsets and field widths for the SD host-bus block.
// Modules refer to these by scoped names.
`default_nettype none

package periph_pkg;

  localparam int ADDR_W = 17;
  localparam int DATA_W = 32;

  // host address bits 16:15
  typedef enum logic [1:0] {
    KEYB   = 2'd0,
    FSTORE = 2'd1,
    SDCTRL = 2'd2,
    SDRX   = 2'd3
  } periph_region_e;

  // write offsets, address bits 5:2
  typedef enum logic [3:0] {
    ALIGN   = 4'd0,
    CMD_ARG = 4'd2,
    CMD_IDX = 4'd3,
    SETTING = 4'd4,
    START   = 4'd5,
    RESETS  = 4'd6,
    BLKCNT  = 4'd7,
    BLKSIZE = 4'd8,
    TIMEOUT = 4'd9,
    LED     = 4'd15
  } sd_wr_off_e;

  // read offsets, address bits 6:2; echoes sit at write offset + 16
  typedef enum logic [4:0] {
    STATUS     = 5'd5,
    RX_STAT    = 5'd10,
    TX_STAT    = 5'd11,
    DETECT     = 5'd12,
    ALIGN_RB   = 5'd16,
    CMD_ARG_RB = 5'd18,
    CMD_IDX_RB = 5'd19,
    SETTING_RB = 5'd20,
    START_RB   = 5'd21,
    RESETS_RB  = 5'd22,
    BLKCNT_RB  = 5'd23,
    BLKSIZE_RB = 5'd24,
    TIMEOUT_RB = 5'd25,
    DIP        = 5'd31
  } sd_rd_off_e;

  localparam int TXFIFO_SEL_BIT = 14;
  localparam logic [DATA_W-1:0] RD_DEFAULT = 32'hDEADBEEF;

  localparam int ALIGN_W   = 2;
  localparam int CMD_IDX_W = 6;
  localparam int SETTING_W = 3; // data start uses the same width
  localparam int BLKCNT_W  = 16;
  localparam int BLKSIZE_W = 12;
  localparam int LED_W     = 8;
  localparam int DIP_W     = 16;
  localparam int RESETS_W  = 4; // card, clock, data, command

  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_CNT_W = 12;

endpackage

`default_nettype wire
